// ==== design/tm_config.svh ====
`ifndef TM_CONFIG_SVH
`define TM_CONFIG_SVH

`define TM_TAPE_AW     10
`define TM_STATE_W     8
`define TM_HALT_STATE  8'hFF

// Tape symbols
`define SYM_BLANK      2'b00
`define SYM_ZERO       2'b01
`define SYM_ONE        2'b10
`define SYM_HASH       2'b11

// PS/2 set 2 make codes
`define KEY_ZERO       8'h45
`define KEY_ONE        8'h16
`define KEY_TWO        8'h1E
`define KEY_THREE      8'h26
`define KEY_FOUR       8'h25
`define KEY_FIVE       8'h2E
`define KEY_SIX        8'h36
`define KEY_SEVEN      8'h3D
`define KEY_EIGHT      8'h3E
`define KEY_NINE       8'h46
`define KEY_A          8'h1C
`define KEY_B          8'h32
`define KEY_C          8'h21
`define KEY_D          8'h23
`define KEY_E          8'h24
`define KEY_F          8'h2B
`define KEY_SPACE      8'h29
`define KEY_ENTER      8'h5A
`define KEY_BACK       8'h66

`endif

// ==== design/tm_pkg.sv ====
`include "tm_config.svh"

package tm_pkg;

	typedef logic [7:0] scan_code_t;
	typedef logic [1:0] sym_t;
	typedef logic [`TM_TAPE_AW-1:0] tape_addr_t;
	typedef logic [`TM_STATE_W-1:0] tm_state_t;

	// State in the upper bits, read symbol in the lower two
	typedef logic [`TM_STATE_W+1:0] rule_addr_t;

	typedef struct packed {
		sym_t      wr_sym;
		logic      dir;        // 0 left, 1 right
		tm_state_t next_state;
	} rule_t;

	typedef struct packed {
		logic       valid;
		logic       is_hex;
		logic [3:0] hex;
		logic       is_sym;
		sym_t       sym;
		logic       enter;
		logic       back;
	} key_event_t;

	typedef struct packed {
		logic wr;
		sym_t sym;
		logic move;
		logic dir;
	} tape_cmd_t;

	typedef enum logic [1:0] {
		MODE_MENU,
		MODE_TAPE,
		MODE_RULE,
		MODE_RUN
	} mode_t;

endpackage

// ==== design/key_console.sv ====
`timescale 1ns/1ps
`include "tm_config.svh"

module key_console import tm_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       key_valid,
	input  scan_code_t key_code,
	input  logic       req_run,
	input  logic       req_menu,
	input  logic       exec_done,
	output mode_t      mode,
	output key_event_t rule_key,
	output key_event_t tape_key,
	output logic       run_start
);

	key_event_t ev;

	// One scan code can be both hex and symbol
	always_comb begin
		ev = '0;
		ev.valid = key_valid;
		ev.is_hex = 1'b1;
		case (key_code)
			`KEY_ZERO:  ev.hex = 4'h0;
			`KEY_ONE:   ev.hex = 4'h1;
			`KEY_TWO:   ev.hex = 4'h2;
			`KEY_THREE: ev.hex = 4'h3;
			`KEY_FOUR:  ev.hex = 4'h4;
			`KEY_FIVE:  ev.hex = 4'h5;
			`KEY_SIX:   ev.hex = 4'h6;
			`KEY_SEVEN: ev.hex = 4'h7;
			`KEY_EIGHT: ev.hex = 4'h8;
			`KEY_NINE:  ev.hex = 4'h9;
			`KEY_A:     ev.hex = 4'hA;
			`KEY_B:     ev.hex = 4'hB;
			`KEY_C:     ev.hex = 4'hC;
			`KEY_D:     ev.hex = 4'hD;
			`KEY_E:     ev.hex = 4'hE;
			`KEY_F:     ev.hex = 4'hF;
			default:    ev.is_hex = 1'b0;
		endcase
		ev.is_sym = 1'b1;
		case (key_code)
			`KEY_SPACE: ev.sym = `SYM_BLANK;
			`KEY_ZERO:  ev.sym = `SYM_ZERO;
			`KEY_ONE:   ev.sym = `SYM_ONE;
			`KEY_THREE: ev.sym = `SYM_HASH;   // Hash shares the "3" key
			default:    ev.is_sym = 1'b0;
		endcase
		ev.enter = (key_code == `KEY_ENTER);
		ev.back = (key_code == `KEY_BACK);
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			mode <= MODE_MENU;
			rule_key <= '0;
			tape_key <= '0;
			run_start <= 1'b0;
		end else begin
			rule_key <= '0;
			tape_key <= '0;
			run_start <= req_run;
			if (req_run) begin
				mode <= MODE_RUN;
			end else if (req_menu || exec_done) begin
				mode <= MODE_MENU;
			end else if (key_valid) begin
				// Routing uses the mode the key arrived in
				case (mode)
					MODE_MENU: begin
						if (ev.is_hex && ev.hex == 4'h0)
							mode <= MODE_TAPE;
						else if (ev.is_hex && ev.hex == 4'h1)
							mode <= MODE_RULE;
					end
					MODE_TAPE: begin
						if (ev.enter)
							mode <= MODE_RULE;
						else
							tape_key <= ev;
					end
					MODE_RULE: rule_key <= ev;
					default: ;   // Keys dropped while running
				endcase
			end
		end
	end

endmodule

// ==== design/rule_entry.sv ====
`timescale 1ns/1ps

module rule_entry import tm_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  key_event_t key,
	input  rule_addr_t rule_addr,
	output logic       req_run,
	output logic       req_menu,
	output rule_t      rule,
	output logic       rule_valid
);

	localparam int DEPTH = 1 << $bits(rule_addr_t);

	typedef enum logic [2:0] {
		F_STATE_HI,
		F_STATE_LO,
		F_READ,
		F_WRITE,
		F_DIR,
		F_NS_HI,
		F_NS_LO
	} field_t;

	field_t           field;
	logic             accept;
	logic             wr_en;
	rule_addr_t       new_addr;
	rule_t            new_rule;
	rule_t            wr_rule;
	rule_t            table_mem [DEPTH];
	logic [DEPTH-1:0] valid_bits;

	// Only keys that fit the current field move it on
	always_comb begin
		case (field)
			F_READ, F_WRITE: accept = key.is_sym;
			F_DIR:           accept = key.is_hex && (key.hex == 4'hA || key.hex == 4'hD);
			default:         accept = key.is_hex;
		endcase
		accept = accept && key.valid;
		wr_en = accept && (field == F_NS_LO);
		// Low next-state digit goes to the table straight from the key
		wr_rule.wr_sym = new_rule.wr_sym;
		wr_rule.dir = new_rule.dir;
		wr_rule.next_state = {new_rule.next_state[7:4], key.hex};
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			field <= F_STATE_HI;
			req_run <= 1'b0;
			req_menu <= 1'b0;
			valid_bits <= '0;
			rule_valid <= 1'b0;
		end else begin
			req_run <= key.valid && field == F_STATE_HI && key.enter;
			req_menu <= key.valid && field == F_STATE_HI && key.back;
			if (accept)
				field <= (field == F_NS_LO) ? F_STATE_HI : field_t'(field + 3'd1);
			if (wr_en)
				valid_bits[new_addr] <= 1'b1;
			rule_valid <= valid_bits[rule_addr];
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			case (field)
				F_STATE_HI: new_addr[9:6] <= key.hex;
				F_STATE_LO: new_addr[5:2] <= key.hex;
				F_READ:     new_addr[1:0] <= key.sym;
				F_WRITE:    new_rule.wr_sym <= key.sym;
				F_DIR:      new_rule.dir <= (key.hex == 4'hD);
				F_NS_HI:    new_rule.next_state[7:4] <= key.hex;
				default:    ;
			endcase
		end
		if (wr_en)
			table_mem[new_addr] <= wr_rule;
		rule <= table_mem[rule_addr];   // Executor read port
	end

endmodule

// ==== design/tape_editor.sv ====
`timescale 1ns/1ps
`include "tm_config.svh"

module tape_editor import tm_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  key_event_t key,
	input  tape_cmd_t  exec_cmd,
	input  tape_addr_t view_addr,
	output sym_t       view_sym,
	output tape_addr_t head_pos,
	output sym_t       head_sym
);

	localparam int DEPTH = 1 << $bits(tape_addr_t);

	sym_t      tape [DEPTH];
	tape_cmd_t key_cmd;
	tape_cmd_t cmd;

	always_comb begin
		key_cmd = '0;
		if (key.back) begin
			// Delete clears the cell and steps left
			key_cmd.wr = 1'b1;
			key_cmd.sym = `SYM_BLANK;
			key_cmd.move = 1'b1;
			key_cmd.dir = 1'b0;
		end else if (key.is_sym) begin
			key_cmd.wr = 1'b1;
			key_cmd.sym = key.sym;
		end else if (key.is_hex && key.hex == 4'hA) begin
			key_cmd.move = 1'b1;
			key_cmd.dir = 1'b0;
		end else if (key.is_hex && key.hex == 4'hD) begin
			key_cmd.move = 1'b1;
			key_cmd.dir = 1'b1;
		end
		cmd = key.valid ? key_cmd : exec_cmd;   // Never both at once
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			head_pos <= '0;
		end else if (cmd.move) begin
			// Wraps at both ends of the tape
			if (cmd.dir)
				head_pos <= tape_addr_t'(head_pos + 1'b1);
			else
				head_pos <= tape_addr_t'(head_pos - 1'b1);
		end
	end

	always_ff @(posedge clk) begin
		if (cmd.wr)
			tape[head_pos] <= cmd.sym;
		head_sym <= tape[head_pos];
		view_sym <= tape[view_addr];   // View port
	end

endmodule

// ==== design/tm_executor.sv ====
`timescale 1ns/1ps
`include "tm_config.svh"

module tm_executor import tm_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       run_start,
	input  sym_t       head_sym,
	input  rule_t      rule,
	input  logic       rule_valid,
	output rule_addr_t rule_addr,
	output tape_cmd_t  exec_cmd,
	output tm_state_t  tm_state,
	output logic       done
);

	typedef enum logic [1:0] {
		EX_IDLE,
		EX_READ,
		EX_LOOKUP,
		EX_APPLY
	} ex_state_t;

	ex_state_t ex;

	assign rule_addr = {tm_state, head_sym};

	always_comb begin
		exec_cmd = '0;
		if (ex == EX_APPLY && rule_valid) begin
			exec_cmd.wr = 1'b1;
			exec_cmd.sym = rule.wr_sym;
			exec_cmd.move = 1'b1;
			exec_cmd.dir = rule.dir;
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			ex <= EX_IDLE;
			tm_state <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			case (ex)
				EX_IDLE: begin
					if (run_start) begin
						tm_state <= '0;
						ex <= EX_READ;
					end
				end
				EX_READ:   ex <= EX_LOOKUP;   // head_sym settles after the last move
				EX_LOOKUP: ex <= EX_APPLY;
				default: begin
					if (!rule_valid) begin
						// No rule for this state and symbol
						done <= 1'b1;
						ex <= EX_IDLE;
					end else begin
						tm_state <= rule.next_state;
						if (rule.next_state == `TM_HALT_STATE) begin
							done <= 1'b1;
							ex <= EX_IDLE;
						end else begin
							ex <= EX_READ;
						end
					end
				end
			endcase
		end
	end

endmodule

// ==== design/tm_top.sv ====
`timescale 1ns/1ps

module tm_top import tm_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       key_valid,
	input  scan_code_t key_code,
	input  tape_addr_t view_addr,
	output sym_t       view_sym,
	output mode_t      mode,
	output tape_addr_t head_pos,
	output tm_state_t  tm_state,
	output logic       halted
);

	key_event_t rule_key;
	key_event_t tape_key;
	logic       req_run;
	logic       req_menu;
	logic       run_start;
	rule_addr_t rule_addr;
	rule_t      rule;
	logic       rule_valid;
	tape_cmd_t  exec_cmd;
	sym_t       head_sym;

	key_console u_console (
		.clk       (clk),
		.rst       (rst),
		.key_valid (key_valid),
		.key_code  (key_code),
		.req_run   (req_run),
		.req_menu  (req_menu),
		.exec_done (halted),
		.mode      (mode),
		.rule_key  (rule_key),
		.tape_key  (tape_key),
		.run_start (run_start)
	);

	rule_entry u_rules (
		.clk        (clk),
		.rst        (rst),
		.key        (rule_key),
		.rule_addr  (rule_addr),
		.req_run    (req_run),
		.req_menu   (req_menu),
		.rule       (rule),
		.rule_valid (rule_valid)
	);

	tape_editor u_tape (
		.clk       (clk),
		.rst       (rst),
		.key       (tape_key),
		.exec_cmd  (exec_cmd),
		.view_addr (view_addr),
		.view_sym  (view_sym),
		.head_pos  (head_pos),
		.head_sym  (head_sym)
	);

	tm_executor u_exec (
		.clk        (clk),
		.rst        (rst),
		.run_start  (run_start),
		.head_sym   (head_sym),
		.rule       (rule),
		.rule_valid (rule_valid),
		.rule_addr  (rule_addr),
		.exec_cmd   (exec_cmd),
		.tm_state   (tm_state),
		.done       (halted)
	);

endmodule

// ==== test/tb_tm_tasks.svh ====
`ifndef TB_TM_TASKS_SVH
`define TB_TM_TASKS_SVH

// One strobe, then the rest of the key gap; returns on a falling edge
task automatic press_key(input scan_code_t code);
	@(posedge clk);
	key_valid <= 1'b1;
	key_code <= code;
	@(posedge clk);
	key_valid <= 1'b0;
	repeat (KEY_GAP - 2) @(posedge clk);
	@(negedge clk);
endtask

task automatic mode_key(input scan_code_t code, input mode_t next_mode);
	press_key(code);
	m_mode = next_mode;
	assert (mode == m_mode)
		else report_error($sformatf("mode %s, expected %s", mode.name(), m_mode.name()));
endtask

function automatic void put_sym(input sym_t s);
	m_tape[m_head] = s;
	m_known[m_head] = 1'b1;
endfunction

task automatic tape_key(input scan_code_t code);
	press_key(code);
	case (code)
		`KEY_A:     m_head = m_head - 1'b1;
		`KEY_D:     m_head = m_head + 1'b1;
		`KEY_SPACE: put_sym(`SYM_BLANK);
		`KEY_ZERO:  put_sym(`SYM_ZERO);
		`KEY_ONE:   put_sym(`SYM_ONE);
		`KEY_THREE: put_sym(`SYM_HASH);
		`KEY_BACK: begin
			put_sym(`SYM_BLANK);
			m_head = m_head - 1'b1;
		end
		default: ;
	endcase
	assert (head_pos == m_head)
		else report_error($sformatf("head_pos %0d, expected %0d", head_pos, m_head));
	assert (mode == MODE_TAPE) else report_error("mode left MODE_TAPE during editing");
endtask

// Seven fields, each optionally preceded by a key that does not fit it
task automatic key_rule(input tm_state_t st, input sym_t rd, input rule_t r, input bit noisy);
	scan_code_t seq [7];
	rule_addr_t a;
	seq = '{HEX_CODES[st[7:4]], HEX_CODES[st[3:0]], SYM_CODES[rd], SYM_CODES[r.wr_sym],
		r.dir ? `KEY_D : `KEY_A, HEX_CODES[r.next_state[7:4]], HEX_CODES[r.next_state[3:0]]};
	for (int f = 0; f < 7; f++) begin
		if (noisy && ($urandom % 2 == 1))
			mode_key(BAD_KEYS[f], MODE_RULE);
		mode_key(seq[f], MODE_RULE);
	end
	a = {st, rd};
	m_rule[a] = r;
	m_rvalid[a] = 1'b1;
endtask

task automatic check_tape();
	for (int i = 0; i < 1024; i++) begin
		if (m_known[i]) begin
			@(posedge clk);
			view_addr <= tape_addr_t'(i);
			repeat (2) @(posedge clk);
			@(negedge clk);
			assert (view_sym == m_tape[i])
				else report_error($sformatf("cell %0d holds %0d, expected %0d",
					i, view_sym, m_tape[i]));
		end
	end
endtask

`endif

// ==== test/tb_tm_top.sv ====
`timescale 1ns/1ps
`include "tm_config.svh"

module tb_tm_top import tm_pkg::*; ();

	localparam int KEY_GAP = 8;
	localparam int ONES = 20;   // Length of the unary number
	// Menu 4, tape 61, rules 44, run setup, run and menu keys 8, missing rule 4
	localparam int KEY_COUNT = 4 + 61 + 44 + (2 * ONES + 1) + 8 + 4;
	localparam int RUN_BUDGET = 2 * (3 * (ONES + 2) + 16);
	localparam int READ_BUDGET = 3 * 128 * 4;
	localparam int LIMIT = 2 * KEY_COUNT * KEY_GAP + RUN_BUDGET + READ_BUDGET;

	localparam scan_code_t HEX_CODES [16] = '{`KEY_ZERO, `KEY_ONE, `KEY_TWO, `KEY_THREE,
		`KEY_FOUR, `KEY_FIVE, `KEY_SIX, `KEY_SEVEN, `KEY_EIGHT, `KEY_NINE,
		`KEY_A, `KEY_B, `KEY_C, `KEY_D, `KEY_E, `KEY_F};
	localparam scan_code_t SYM_CODES [4] = '{`KEY_SPACE, `KEY_ZERO, `KEY_ONE, `KEY_THREE};
	localparam scan_code_t BAD_KEYS [7] = '{`KEY_SPACE, `KEY_ENTER, `KEY_TWO, `KEY_A,
		`KEY_B, `KEY_BACK, `KEY_SPACE};
	localparam scan_code_t TAPE_KEYS [7] = '{`KEY_A, `KEY_D, `KEY_SPACE, `KEY_ZERO,
		`KEY_ONE, `KEY_THREE, `KEY_BACK};

	logic       clk;
	logic       rst;
	logic       key_valid;
	scan_code_t key_code;
	tape_addr_t view_addr;
	sym_t       view_sym;
	mode_t      mode;
	tape_addr_t head_pos;
	tm_state_t  tm_state;
	logic       halted;

	// Reference model
	sym_t       m_tape [1024];
	bit         m_known [1024];
	tape_addr_t m_head;
	rule_t      m_rule [1024];
	bit         m_rvalid [1024];
	mode_t      m_mode;
	tm_state_t  m_state;

	int cycles = 0;
	int halt_count = 0;
	int halt_target = 0;

	task automatic stop_run(input string line);
		$display("%s", line);
		$display("*** TEST FAILED ***");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic report_error(input string msg);
		stop_run($sformatf("Error at %0t ns: %s", $time, msg));
	endtask

	`include "tb_tm_tasks.svh"

	task automatic model_run();
		rule_addr_t a;
		int steps;
		m_state = '0;
		steps = 0;
		while (1) begin
			assert (m_known[m_head]) else stop_run("Model run reached a cell never written");
			a = {m_state, m_tape[m_head]};
			if (!m_rvalid[a])
				break;   // Halts in place without a matching rule
			put_sym(m_rule[a].wr_sym);
			m_head = m_rule[a].dir ? m_head + 1'b1 : m_head - 1'b1;
			m_state = m_rule[a].next_state;
			steps++;
			if (m_state == `TM_HALT_STATE || steps > 1000)
				break;
		end
	endtask

	task automatic start_run();
		int n;
		n = 0;
		@(posedge clk);
		key_valid <= 1'b1;
		key_code <= `KEY_ENTER;
		@(posedge clk);
		key_valid <= 1'b0;
		@(negedge clk);
		while (mode != MODE_RUN && n < 4) begin
			@(negedge clk);
			n++;
		end
		assert (mode == MODE_RUN)
			else report_error("Enter on the first field did not start a run");
		m_mode = MODE_RUN;
		halt_target++;
	endtask

	task automatic check_halt();
		while (halt_count < halt_target)
			@(negedge clk);
		assert (tm_state == m_state)
			else report_error($sformatf("tm_state %h, expected %h", tm_state, m_state));
		assert (head_pos == m_head)
			else report_error($sformatf("head_pos %0d, expected %0d", head_pos, m_head));
		assert (mode == MODE_MENU) else report_error("mode is not MODE_MENU after the halt");
		m_mode = MODE_MENU;
		check_tape();
	endtask

	tm_top DUT (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(negedge clk) begin
		if (halted)
			halt_count <= halt_count + 1;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > LIMIT)
			stop_run($sformatf("Timeout: the test did not finish within %0d cycles", LIMIT));
	end

	assert property (@(posedge clk) disable iff (!rst) halted |=> mode == MODE_MENU)
		else report_error("mode did not return to MODE_MENU after halted");
	assert property (@(posedge clk) disable iff (!rst) halted |-> mode == MODE_RUN)
		else report_error("halted pulsed outside a run");
	// Only a halt ends a run
	assert property (@(posedge clk) disable iff (!rst)
		mode == MODE_RUN && !halted |=> mode == MODE_RUN)
		else report_error("mode left MODE_RUN before halted");

	initial begin
		int unused;
		rst = 1'b0;
		key_valid = 1'b0;
		key_code = '0;
		view_addr = '0;
		m_head = '0;
		m_mode = MODE_MENU;
		unused = $urandom(32'h3750);
		repeat (8) @(posedge clk);
		rst <= 1'b1;
		@(negedge clk);
		assert (mode == MODE_MENU && !halted && head_pos == '0 && tm_state == '0)
			else report_error("outputs are not at their reset values");
		mode_key(`KEY_TWO, MODE_MENU);
		mode_key(`KEY_SPACE, MODE_MENU);
		mode_key(`KEY_ENTER, MODE_MENU);
		mode_key(`KEY_BACK, MODE_MENU);

		mode_key(`KEY_ZERO, MODE_TAPE);
		tape_key(`KEY_ONE);
		tape_key(`KEY_A);   // Head wraps below cell 0
		tape_key(`KEY_THREE);
		repeat (57) tape_key(TAPE_KEYS[$urandom % 7]);
		check_tape();

		mode_key(`KEY_ENTER, MODE_RULE);
		key_rule(8'h00, `SYM_ONE, '{`SYM_ONE, 1'b1, 8'h00}, 1'b1);
		key_rule(8'h00, `SYM_BLANK, '{`SYM_ONE, 1'b1, `TM_HALT_STATE}, 1'b1);
		key_rule(8'h3C, `SYM_HASH, '{`SYM_ZERO, 1'b0, 8'h5A}, 1'b1);
		mode_key(`KEY_BACK, MODE_MENU);

		// Unary number left of a blank with the head on its first digit
		mode_key(`KEY_ZERO, MODE_TAPE);
		tape_key(`KEY_SPACE);
		repeat (ONES) begin
			tape_key(`KEY_A);
			tape_key(`KEY_ONE);
		end
		mode_key(`KEY_ENTER, MODE_RULE);
		model_run();
		start_run();
		press_key(`KEY_SPACE);   // Dropped while running
		press_key(`KEY_D);
		press_key(`KEY_THREE);
		check_halt();
		mode_key(`KEY_ONE, MODE_RULE);
		mode_key(`KEY_BACK, MODE_MENU);   // Works only if the field is still the first

		mode_key(`KEY_ZERO, MODE_TAPE);
		tape_key(`KEY_THREE);
		mode_key(`KEY_ENTER, MODE_RULE);
		model_run();
		start_run();
		check_halt();

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

// ==== files.f ====
+incdir+design
+incdir+test
design/tm_pkg.sv
design/key_console.sv
design/rule_entry.sv
design/tape_editor.sv
design/tm_executor.sv
design/tm_top.sv
test/tb_tm_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the testbench with Verilator, pass only if the pass line appears
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f files.f --top-module tb_tm_top -o tb_tm_top &&
	./obj_dir/tb_tm_top | tee /dev/stderr | grep -qF "*** TEST PASSED ***" &&
	echo "Simulation passed" ||
	{ echo "Simulation failed"; exit 1; }
